// File: Makefile
TOOL   := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := tb_cgra_conf
FLIST  := cgra_conf_top.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: cgra_conf_top.f
+incdir+include
hdl/cgra_conf_pkg.sv
hdl/conf_line_if.sv
hdl/conf_line_fifo.sv
hdl/conf_loader.sv
hdl/conf_dispatch.sv
hdl/pe_conf_store.sv
hdl/cgra_conf_top.sv
tb/tb_clk_gen.sv
tb/tb_cgra_conf.sv

// File: hdl/cgra_conf_pkg.sv
`include "cgra_conf_cfg.svh"

package cgra_conf_pkg;

  // first line of a configuration stream.
  typedef struct packed {
    logic [`CONF_LINE_W-66-1:0] rsvd_hi;  // bits 511:66.
    logic [1:0]                 wr_fifo_mask;
    logic [29:0]                rsvd_mid; // bits 63:34.
    logic [1:0]                 rd_fifo_mask;
    logic [31:0]                word_count;
  } conf_hdr_t;

  // one configuration word as seen by the dispatcher.
  typedef struct packed {
    logic [`CONF_WORD_W-`CONF_PE_DATA_W-1:0] pe_idx;
    logic [`CONF_PE_DATA_W-1:0]              pe_data;
  } conf_word_t;

  // header view for the first line, word view for every later one.
  // words[0] sits in bits 63:0 and goes out first.
  typedef union packed {
    conf_hdr_t                                           hdr;
    logic [`CONF_WORDS_PER_LINE-1:0][`CONF_WORD_W-1:0]   words;
  } conf_line_u;

endpackage

// File: hdl/cgra_conf_top.sv
`timescale 1ns/100ps
`include "cgra_conf_cfg.svh"

module cgra_conf_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic                            line_req,
  input  logic [`CONF_LINE_W-1:0]         line_data,
  input  logic [$clog2(`CONF_NUM_PE)-1:0] rd_pe,
  output logic                            line_ack,
  output logic [1:0]                      read_fifo_mask,
  output logic [1:0]                      write_fifo_mask,
  output logic                            done,
  output logic [`CONF_PE_DATA_W-1:0]      rd_data,
  output logic [15:0]                     bad_word_count
);

  cgra_conf_pkg::conf_line_u           line_in;
  logic                                conf_valid;
  cgra_conf_pkg::conf_word_t           conf_word;
  logic                                wr_en;
  logic [$clog2(`CONF_NUM_PE)-1:0]     wr_pe;
  logic [`CONF_PE_DATA_W-1:0]          wr_data;

  conf_line_if lines ();

  assign line_in = line_data;

  conf_line_fifo u_line_fifo (
    .clk       (clk),
    .rst       (rst),
    .line_req  (line_req),
    .line_data (line_in),
    .line_ack  (line_ack),
    .lines     (lines.src)
  );

  conf_loader u_loader (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .lines           (lines.dst),
    .conf_valid      (conf_valid),
    .conf_word       (conf_word),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .done            (done)
  );

  conf_dispatch u_dispatch (
    .clk            (clk),
    .rst            (rst),
    .conf_valid     (conf_valid),
    .conf_word      (conf_word),
    .wr_en          (wr_en),
    .wr_pe          (wr_pe),
    .wr_data        (wr_data),
    .bad_word_count (bad_word_count)
  );

  pe_conf_store u_store (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_pe   (wr_pe),
    .wr_data (wr_data),
    .rd_pe   (rd_pe),
    .rd_data (rd_data)
  );

endmodule

// File: hdl/conf_dispatch.sv
`timescale 1ns/100ps
`include "cgra_conf_cfg.svh"

module conf_dispatch (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               conf_valid,
  input  cgra_conf_pkg::conf_word_t          conf_word,
  output logic                               wr_en,
  output logic [$clog2(`CONF_NUM_PE)-1:0]    wr_pe,
  output logic [`CONF_PE_DATA_W-1:0]         wr_data,
  output logic [15:0]                        bad_word_count
);

  localparam int NUM_PE = `CONF_NUM_PE;
  localparam int PE_W = $clog2(NUM_PE);
  localparam int IDX_W = `CONF_WORD_W - `CONF_PE_DATA_W;

  logic in_range;
  logic bad_word;

  assign in_range = (conf_word.pe_idx < IDX_W'(NUM_PE));
  assign bad_word = conf_valid && !in_range;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en <= 1'b0;
      bad_word_count <= '0;
    end else begin
      wr_en <= conf_valid && in_range;
      if (bad_word && (bad_word_count != '1)) begin
        bad_word_count <= bad_word_count + 1'b1; // saturates.
      end
    end
  end

  // write address and payload.
  always_ff @(posedge clk) begin
    if (conf_valid && in_range) begin
      wr_pe <= conf_word.pe_idx[PE_W-1:0];
      wr_data <= conf_word.pe_data;
    end
  end

  // a write always stems from an in-range word of the previous cycle.
  a_wr_in_range: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> $past(conf_valid) && ($past(conf_word.pe_idx) == IDX_W'(wr_pe)));

endmodule

// File: hdl/conf_line_fifo.sv
`timescale 1ns/100ps
`include "cgra_conf_cfg.svh"

module conf_line_fifo (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      line_req,
  input  cgra_conf_pkg::conf_line_u line_data,
  output logic                      line_ack,
  conf_line_if.src                  lines
);

  localparam int DEPTH = `CONF_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic ACC_IDLE = 1'b0;
  localparam logic ACC_ACK = 1'b1;

  cgra_conf_pkg::conf_line_u mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [CNT_W-1:0]          count;
  logic                      acc_state;
  logic                      full;
  logic                      push;
  logic                      pop;

  assign full = (count == CNT_W'(DEPTH));
  assign push = (acc_state == ACC_IDLE) && line_req && !full; // held off while full.
  assign pop = lines.req && (count != '0);
  assign line_ack = (acc_state == ACC_ACK);
  assign lines.available = (count != '0);

  // host side four-phase acceptor.
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_state <= ACC_IDLE;
    end else begin
      case (acc_state)
        ACC_IDLE: begin
          if (push) begin
            acc_state <= ACC_ACK;
          end
        end
        ACC_ACK: begin
          if (!line_req) begin
            acc_state <= ACC_IDLE; // ack drops after req is seen low.
          end
        end
        default: acc_state <= ACC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      lines.valid <= 1'b0;
    end else begin
      lines.valid <= pop;
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= line_data;
    end
    if (pop) begin
      lines.data <= mem[rd_ptr];
    end
  end

  // a push into a full buffer would lift the count past the depth.
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    count <= CNT_W'(DEPTH));

  // the loader only pops what is there.
  a_pop_available: assert property (@(posedge clk) disable iff (rst)
    lines.req |-> lines.available);

endmodule

// File: hdl/conf_line_if.sv
`timescale 1ns/100ps

interface conf_line_if;

  logic                      available; // fifo holds at least one line.
  logic                      req;       // single-cycle pop.
  cgra_conf_pkg::conf_line_u data;
  logic                      valid;     // one cycle after req.

  modport src (
    output available,
    output data,
    output valid,
    input  req
  );

  modport dst (
    input  available,
    input  data,
    input  valid,
    output req
  );

endinterface

// File: hdl/conf_loader.sv
`timescale 1ns/100ps
`include "cgra_conf_cfg.svh"

module conf_loader (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  conf_line_if.dst                  lines,
  output logic                      conf_valid,
  output cgra_conf_pkg::conf_word_t conf_word,
  output logic [1:0]                read_fifo_mask,
  output logic [1:0]                write_fifo_mask,
  output logic                      done
);

  localparam logic [2:0] ST_IDLE = 3'd0;
  localparam logic [2:0] ST_REQ = 3'd1;
  localparam logic [2:0] ST_WAIT = 3'd2;
  localparam logic [2:0] ST_HDR = 3'd3;
  localparam logic [2:0] ST_SEND = 3'd4;
  localparam logic [2:0] ST_DRAIN = 3'd5;
  localparam logic [2:0] ST_DONE = 3'd6;

  localparam int WPL = `CONF_WORDS_PER_LINE;
  localparam int IDX_W = $clog2(WPL);
  localparam int DRAIN = `CONF_DRAIN_CYCLES;
  localparam int DRAIN_W = $clog2(DRAIN + 1);

  logic [2:0]                state;
  logic [2:0]                ret_state;  // where to go once the line lands.
  cgra_conf_pkg::conf_line_u line;
  cgra_conf_pkg::conf_hdr_t  hdr;
  logic [31:0]               word_count;
  logic [31:0]               sent_count;
  logic [IDX_W-1:0]          word_idx;   // position within the current line.
  logic [DRAIN_W-1:0]        drain_cnt;
  logic                      req;

  assign hdr = line.hdr;
  assign lines.req = req;

  // line buffer, shifted down one word per send.
  always_ff @(posedge clk) begin
    if ((state == ST_WAIT) && lines.valid) begin
      line <= lines.data;
    end else if (state == ST_SEND) begin
      line.words <= line.words >> `CONF_WORD_W;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      ret_state <= ST_HDR;
      req <= 1'b0;
      word_count <= '0;
      sent_count <= '0;
      word_idx <= '0;
      drain_cnt <= '0;
      read_fifo_mask <= '0;
      write_fifo_mask <= '0;
      done <= 1'b0;
      conf_valid <= 1'b0;
      conf_word <= '0;
    end else begin
      req <= 1'b0;
      conf_valid <= 1'b0;
      conf_word <= '0; // bus idles at zero.
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_REQ;
            ret_state <= ST_HDR;
          end
        end
        ST_REQ: begin
          if (lines.available) begin
            req <= 1'b1;
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (lines.valid) begin
            state <= ret_state;
          end
        end
        ST_HDR: begin
          word_count <= hdr.word_count;
          read_fifo_mask <= hdr.rd_fifo_mask;
          write_fifo_mask <= hdr.wr_fifo_mask;
          sent_count <= '0;
          word_idx <= '0;
          drain_cnt <= '0;
          if (hdr.word_count == 32'd0) begin
            state <= ST_DRAIN; // empty stream.
          end else begin
            state <= ST_REQ;
            ret_state <= ST_SEND;
          end
        end
        ST_SEND: begin
          conf_valid <= 1'b1;
          conf_word <= cgra_conf_pkg::conf_word_t'(line.words[0]);
          sent_count <= sent_count + 32'd1;
          word_idx <= word_idx + 1'b1;
          if (sent_count + 32'd1 == word_count) begin
            state <= ST_DRAIN; // rest of the line is dropped.
          end else if (word_idx == IDX_W'(WPL - 1)) begin
            state <= ST_REQ;
          end
        end
        ST_DRAIN: begin
          if (drain_cnt == DRAIN_W'(DRAIN - 1)) begin
            done <= 1'b1;
            state <= ST_DONE;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        ST_DONE: begin
          done <= 1'b1; // held until reset.
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // nothing leaves the loader once the stream is closed.
  a_quiet_after_done: assert property (@(posedge clk) disable iff (rst)
    done |-> !conf_valid);

endmodule

// File: hdl/pe_conf_store.sv
`timescale 1ns/100ps
`include "cgra_conf_cfg.svh"

module pe_conf_store (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            wr_en,
  input  logic [$clog2(`CONF_NUM_PE)-1:0] wr_pe,
  input  logic [`CONF_PE_DATA_W-1:0]      wr_data,
  input  logic [$clog2(`CONF_NUM_PE)-1:0] rd_pe,
  output logic [`CONF_PE_DATA_W-1:0]      rd_data
);

  localparam int NUM_PE = `CONF_NUM_PE;

  logic [`CONF_PE_DATA_W-1:0] pe_regs [NUM_PE];

  // store is part of the reset state.
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_PE; i++) begin
        pe_regs[i] <= '0;
      end
    end else if (wr_en) begin
      pe_regs[wr_pe] <= wr_data; // last write wins.
    end
  end

  // registered readback.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= '0;
    end else begin
      rd_data <= pe_regs[rd_pe];
    end
  end

endmodule

// File: include/cgra_conf_cfg.svh
`ifndef CGRA_CONF_CFG_SVH
`define CGRA_CONF_CFG_SVH

// configuration line and word geometry.
`define CONF_LINE_W 512
`define CONF_WORD_W 64
`define CONF_WORDS_PER_LINE 8

// pe store.
`define CONF_NUM_PE 16
`define CONF_PE_DATA_W 56

// line fifo depth, in lines.
`define CONF_FIFO_DEPTH 4

// quiet cycles after the last word before done.
`define CONF_DRAIN_CYCLES 41

`endif

// File: tb/tb_cgra_conf.sv
`timescale 1ns/100ps
`include "cgra_conf_cfg.svh"

module tb_cgra_conf;

  localparam int NUM_PE = `CONF_NUM_PE;
  localparam int DEPTH = `CONF_FIFO_DEPTH;
  localparam int WAIT_MAX = 200;
  localparam int DONE_MAX = 600;

  logic clk, rst, rst_go;
  logic start, line_req, line_ack, done;
  logic [`CONF_LINE_W-1:0] line_data;
  logic [3:0] rd_pe;
  logic [1:0] read_fifo_mask, write_fifo_mask;
  logic [`CONF_PE_DATA_W-1:0] rd_data;
  logic [15:0] bad_word_count;

  logic [`CONF_PE_DATA_W-1:0] exp_store [NUM_PE]; // reference model of the store.
  logic [`CONF_PE_DATA_W-1:0] exp_rd;
  logic [1:0] exp_rmask, exp_wmask;
  logic [15:0] exp_bad;
  logic chk_rd, chk_stat, chk_acks, bp_hold;
  cgra_conf_pkg::conf_line_u lq [$];
  logic [15:0] lfsr = 16'd6494;
  int acks, errors, err_at_start, pass_cnt, fail_cnt;
  string test_name;

  tb_clk_gen u_clk_gen (.rst_go(rst_go), .clk(clk), .rst(rst));

  cgra_conf_top u_cgra_conf_top (
    .clk(clk), .rst(rst), .start(start), .line_req(line_req), .line_data(line_data),
    .rd_pe(rd_pe), .line_ack(line_ack), .read_fifo_mask(read_fifo_mask),
    .write_fifo_mask(write_fifo_mask), .done(done), .rd_data(rd_data),
    .bad_word_count(bad_word_count)
  );

  a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> ({done, line_ack,
      read_fifo_mask, write_fifo_mask, bad_word_count, rd_data} == '0))
    else begin
      errors++;
      $display("ERR %s reset state expected 0 actual %h", test_name, $sampled({done,
        line_ack, read_fifo_mask, write_fifo_mask, bad_word_count, rd_data}));
    end

  a_readback: assert property (@(posedge clk) chk_rd |-> rd_data == exp_rd)
    else begin
      errors++;
      $display("ERR %s pe %0d expected %h actual %h", test_name, $sampled(rd_pe),
        $sampled(exp_rd), $sampled(rd_data));
    end

  a_rd_mask: assert property (@(posedge clk) chk_stat |-> read_fifo_mask == exp_rmask)
    else begin
      errors++;
      $display("ERR %s read mask expected %b actual %b", test_name, $sampled(exp_rmask),
        $sampled(read_fifo_mask));
    end

  a_wr_mask: assert property (@(posedge clk) chk_stat |-> write_fifo_mask == exp_wmask)
    else begin
      errors++;
      $display("ERR %s write mask expected %b actual %b", test_name, $sampled(exp_wmask),
        $sampled(write_fifo_mask));
    end

  a_bad_count: assert property (@(posedge clk) chk_stat |-> bad_word_count == exp_bad)
    else begin
      errors++;
      $display("ERR %s bad words expected %0d actual %0d", test_name, $sampled(exp_bad),
        $sampled(bad_word_count));
    end

  a_done_hold: assert property (@(posedge clk) $past(done) && !rst |-> done)
    else begin
      errors++;
      $display("ERR %s done expected 1 actual 0", test_name);
    end

  // host must stall once the fifo is full and nothing pops.
  a_bp_hold: assert property (@(posedge clk) bp_hold |-> acks <= DEPTH)
    else begin
      errors++;
      $display("%s: the fifo took line %0d before start", test_name, $sampled(acks));
    end

  a_bp_acks: assert property (@(posedge clk) chk_acks |-> acks == DEPTH)
    else begin
      errors++;
      $display("ERR %s acks before start expected %0d actual %0d", test_name, DEPTH,
        $sampled(acks));
    end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr); // one step per bit.
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic note_timeout(input string what);
    errors++;
    $display("%s: gave up waiting for %s", test_name, what);
  endtask

  task automatic begin_test(input string name);
    int t;
    test_name = name;
    err_at_start = errors;
    acks = 0;
    exp_bad = '0;
    exp_rmask = '0;
    exp_wmask = '0;
    for (int i = 0; i < NUM_PE; i++) begin
      exp_store[i] = '0;
    end
    rst_go <= 1'b1;
    @(posedge clk);
    rst_go <= 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (rst !== 1'b0 && t < WAIT_MAX);
    if (rst !== 1'b0) note_timeout("reset release");
  endtask

  task automatic end_test();
    if (errors == err_at_start) begin
      pass_cnt++;
      $display("test %s passed", test_name);
    end else begin
      fail_cnt++;
      $display("test %s failed", test_name);
    end
  endtask

  // header first, then nlines lines of words; the model sees only counted words.
  task automatic build_stream(input int wc, input logic [1:0] rm, input logic [1:0] wm,
                              input int nlines, input int idx_bits);
    cgra_conf_pkg::conf_line_u l;
    cgra_conf_pkg::conf_word_t w;
    int n;
    lq.delete();
    l = '0;
    l.hdr.word_count = wc;
    l.hdr.rd_fifo_mask = rm;
    l.hdr.wr_fifo_mask = wm;
    lq.push_back(l);
    exp_rmask = rm;
    exp_wmask = wm;
    n = 0;
    for (int j = 0; j < nlines; j++) begin
      for (int k = 0; k < `CONF_WORDS_PER_LINE; k++) begin
        w.pe_idx = 8'(rand_bits(idx_bits));
        w.pe_data = 56'(rand_bits(`CONF_PE_DATA_W));
        l.words[k] = w;
        if (n < wc) begin
          if (w.pe_idx < 8'(NUM_PE)) exp_store[w.pe_idx[3:0]] = w.pe_data;
          else exp_bad++;
        end
        n++;
      end
      lq.push_back(l);
    end
  endtask

  task automatic send_line(input cgra_conf_pkg::conf_line_u l);
    int t;
    line_data <= l;
    line_req <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (line_ack !== 1'b1 && t < WAIT_MAX);
    if (line_ack !== 1'b1) note_timeout("line_ack");
    else acks++;
    line_req <= 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (line_ack !== 1'b0 && t < WAIT_MAX);
    if (line_ack !== 1'b0) note_timeout("line_ack to drop");
  endtask

  task automatic run_stream(input int start_delay, input logic bp);
    int t;
    fork
      begin
        foreach (lq[i]) send_line(lq[i]);
      end
      begin
        bp_hold <= bp;
        repeat (start_delay) @(posedge clk);
        bp_hold <= 1'b0;
        chk_acks <= bp;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        chk_acks <= 1'b0;
      end
    join
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (done !== 1'b1 && t < DONE_MAX);
    if (done !== 1'b1) note_timeout("done");
  endtask

  task automatic check_all();
    chk_stat <= 1'b1;
    @(posedge clk);
    chk_stat <= 1'b0;
    for (int i = 0; i < NUM_PE; i++) begin
      rd_pe <= 4'(i);
      @(posedge clk);
      @(posedge clk);
      exp_rd <= exp_store[i];
      chk_rd <= 1'b1;
      @(posedge clk);
      chk_rd <= 1'b0;
    end
    @(posedge clk);
  endtask

  initial begin
    errors = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    rst_go = 1'b0;
    start = 1'b0;
    line_req = 1'b0;
    line_data = '0;
    rd_pe = '0;
    exp_rd = '0;
    chk_rd = 1'b0;
    chk_stat = 1'b0;
    chk_acks = 1'b0;
    bp_hold = 1'b0;

    begin_test("reset_state");
    check_all();
    end_test();

    begin_test("full_lines");
    build_stream(16, 2'b10, 2'b01, 2, 4);
    run_stream(1, 1'b0);
    check_all();
    end_test();

    begin_test("partial_line");
    build_stream(11, 2'b01, 2'b11, 2, 4); // last line counts three words.
    run_stream(1, 1'b0);
    check_all();
    end_test();

    begin_test("zero_count");
    build_stream(0, 2'b11, 2'b10, 1, 4);
    run_stream(1, 1'b0);
    check_all();
    end_test();

    begin_test("out_of_range");
    build_stream(13, 2'b10, 2'b10, 2, 5); // last three words lie past the count.
    run_stream(1, 1'b0);
    check_all();
    end_test();

    begin_test("back_pressure");
    build_stream(40, 2'b01, 2'b01, 5, 4);
    run_stream(40, 1'b1); // fifo fills long before start.
    check_all();
    end_test();

    begin_test("done_hold");
    build_stream(8, 2'b11, 2'b11, 1, 4);
    run_stream(1, 1'b0);
    repeat (20) @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    repeat (30) @(posedge clk);
    check_all();
    end_test();

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real HALF_PERIOD = 2.0,
  parameter int  RST_CYCLES = 5
) (
  input  logic rst_go, // restarts the reset window.
  output logic clk,
  output logic rst
);

  int rst_cnt = RST_CYCLES;

  initial clk = 1'b0;
  always #(HALF_PERIOD) clk = ~clk;

  always @(posedge clk) begin
    if (rst_go) begin
      rst_cnt <= RST_CYCLES;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign rst = (rst_cnt != 0);

endmodule
